/* common/cache_pkg.sv */
package cache_pkg;

  ////////////////////////////////////////////////////////////
  // cache geometry
  ////////////////////////////////////////////////////////////

  localparam int ADDR_W          = 16;  // word addressed, 64K words
  localparam int WORD_W          = 16;
  localparam int OFFSET_W        = 3;   // word offset inside a block
  localparam int WORDS_PER_BLOCK = 8;   // 2**OFFSET_W

  typedef logic [ADDR_W-1:0] addr_t;  // word address
  typedef logic [WORD_W-1:0] word_t;  // data word

  ////////////////////////////////////////////////////////////
  // cpu side request
  ////////////////////////////////////////////////////////////

  // held stable by the cpu while stall is high
  typedef struct packed {
    logic  valid;  // request present this cycle
    logic  wr;     // 1 = write, 0 = read
    addr_t addr;
    word_t wdata;  // only meaningful when wr is set
  } cpu_req_t;

  ////////////////////////////////////////////////////////////
  // fill machine
  ////////////////////////////////////////////////////////////

  // idle serves hits and write-through, wait streams a block in
  typedef enum logic {
    IDLE = 1'b0,
    WAIT = 1'b1
  } fill_state_e;

endpackage

/* common/mem_pkg.sv */
package mem_pkg;

  ////////////////////////////////////////////////////////////
  // main memory bus
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic             rd;     // level, held for the whole block read
    logic             wr;     // single cycle write strobe
    cache_pkg::addr_t addr;
    cache_pkg::word_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic             valid;  // one cycle pulse per returned word
    cache_pkg::word_t data;
  } mem_rsp_t;

  ////////////////////////////////////////////////////////////
  // power-up contents
  ////////////////////////////////////////////////////////////

  localparam cache_pkg::word_t MEM_INIT_KEY = 16'ha5c3;

  // word at address a starts out as a ^ key
  function automatic cache_pkg::word_t mem_init_word(input cache_pkg::addr_t a);
    return a ^ MEM_INIT_KEY;
  endfunction

endpackage

/* cache/cache_tag_array.sv */
module cache_tag_array #(
  parameter int NUM_SETS = 16   // power of two
) (
  input  logic             clk,
  input  logic             arst_n,
  input  cache_pkg::addr_t lookup_addr,      // held cpu address
  input  logic             write_tag_array,  // end of fill
  output logic             hit
);
  import cache_pkg::*;

  localparam int IDX_W = $clog2(NUM_SETS);
  localparam int TAG_W = ADDR_W - OFFSET_W - IDX_W;

  logic [TAG_W-1:0] tags [NUM_SETS];  // no reset, valid gates use
  logic [NUM_SETS-1:0] valid;

  logic [IDX_W-1:0] idx;
  logic [TAG_W-1:0] tag;

  // address split: | tag | index | offset |
  assign idx = lookup_addr[OFFSET_W +: IDX_W];
  assign tag = lookup_addr[ADDR_W-1 -: TAG_W];

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid <= '0;  // every set empty after reset
    end else if (write_tag_array) begin
      valid[idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (write_tag_array) begin
      tags[idx] <= tag;  // fill address equals lookup address
    end
  end

  ////////////////////////////////////////////////////////////
  // compare
  ////////////////////////////////////////////////////////////

  // same cycle answer, request valid is applied at the top
  assign hit = valid[idx] && (tags[idx] == tag);

endmodule

/* cache/cache_data_array.sv */
module cache_data_array #(
  parameter int NUM_SETS = 16
) (
  input  logic             clk,
  input  cache_pkg::addr_t cpu_addr,
  input  cache_pkg::word_t cpu_wdata,
  input  logic             cpu_wr,            // 1 = cpu port, 0 = fill port
  input  logic             write_data_array,  // write enable for either port
  input  logic [2:0]       fill_offset,
  input  cache_pkg::word_t fill_data,
  output cache_pkg::word_t rdata
);
  import cache_pkg::*;

  localparam int IDX_W   = $clog2(NUM_SETS);
  localparam int DEPTH   = NUM_SETS * WORDS_PER_BLOCK;
  localparam int WADDR_W = IDX_W + OFFSET_W;

  word_t mem [DEPTH];  // set-major, eight words per set

  logic [WADDR_W-1:0] cpu_waddr;   // set and word of the cpu address
  logic [WADDR_W-1:0] fill_waddr;  // same set, word from the counter

  assign cpu_waddr  = cpu_addr[WADDR_W-1:0];
  assign fill_waddr = {cpu_addr[OFFSET_W +: IDX_W], fill_offset};

  ////////////////////////////////////////////////////////////
  // write port
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (write_data_array) begin
      if (cpu_wr) begin
        mem[cpu_waddr] <= cpu_wdata;   // write hit
      end else begin
        mem[fill_waddr] <= fill_data;  // word back from memory
      end
    end
  end

  // combinational read, only trusted when the tag hits
  assign rdata = mem[cpu_waddr];

endmodule

/* cache/cache_fill_fsm.sv */
module cache_fill_fsm (
  input  logic                clk,
  input  logic                arst_n,
  input  cache_pkg::cpu_req_t cpu_req,           // held while stall is high
  input  logic                miss_detected,     // valid request and no tag match
  input  mem_pkg::mem_rsp_t   mem_rsp,
  output mem_pkg::mem_req_t   mem_req,
  output logic                stall,             // cpu must hold its request
  output logic                write_data_array,  // data array write enable
  output logic                write_tag_array,   // tag + valid write, last fill word
  output logic                cpu_wr,            // selects cpu port on data write
  output logic [2:0]          fill_offset        // word being filled
);
  import cache_pkg::*;

  fill_state_e         state;
  fill_state_e         nxt_state;
  logic [OFFSET_W-1:0] cnt;         // word counter, 0..7
  logic                done;        // eighth word returning this cycle
  logic                wr_hit;      // write-through candidate
  addr_t               block_addr;  // missing block with counter as offset

  ////////////////////////////////////////////////////////////
  // word counter
  ////////////////////////////////////////////////////////////

  // advances once per returned word, wraps back to 0 after the eighth
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= '0;
    end else if (state == WAIT && mem_rsp.valid) begin
      cnt <= cnt + 1'b1;
    end
  end

  assign done = (state == WAIT) && mem_rsp.valid &&
                (cnt == OFFSET_W'(WORDS_PER_BLOCK - 1));

  assign fill_offset = cnt;
  assign block_addr  = {cpu_req.addr[ADDR_W-1:OFFSET_W], cnt};

  // miss_detected already includes valid, so this is a write that hits
  assign wr_hit = cpu_req.valid && cpu_req.wr && !miss_detected;

  ////////////////////////////////////////////////////////////
  // state register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
    end else begin
      state <= nxt_state;
    end
  end

  ////////////////////////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////////////////////////

  always_comb begin
    nxt_state        = state;
    stall            = 1'b0;
    write_data_array = 1'b0;
    write_tag_array  = 1'b0;
    cpu_wr           = 1'b0;
    mem_req.rd       = 1'b0;
    mem_req.wr       = 1'b0;
    mem_req.addr     = cpu_req.addr;   // write-through goes to the cpu address
    mem_req.wdata    = cpu_req.wdata;
    case (state)
      IDLE: begin
        if (miss_detected) begin
          // stall and the block read both start in the miss cycle
          nxt_state    = WAIT;
          stall        = 1'b1;
          mem_req.rd   = 1'b1;
          mem_req.addr = block_addr;
        end else if (wr_hit) begin
          write_data_array = 1'b1;  // array and memory same edge
          cpu_wr           = 1'b1;
          mem_req.wr       = 1'b1;
        end
      end
      WAIT: begin
        stall            = !done;          // drops with the last word
        mem_req.rd       = 1'b1;
        mem_req.addr     = block_addr;
        write_data_array = mem_rsp.valid;  // fill port, cpu_wr stays low
        write_tag_array  = done;
        if (done) begin
          nxt_state = IDLE;  // held request hits next cycle
        end
      end
      default: nxt_state = IDLE;
    endcase
  end

endmodule

/* rtl/main_memory.sv */
module main_memory #(
  parameter int MEM_LATENCY = 3   // 1..15
) (
  input  logic              clk,
  input  logic              arst_n,
  input  mem_pkg::mem_req_t mem_req,
  output mem_pkg::mem_rsp_t mem_rsp
);
  import cache_pkg::*;
  import mem_pkg::*;

  localparam int MEM_WORDS = 1 << ADDR_W;
  localparam int CNT_W     = 4;

  word_t            mem [MEM_WORDS];
  logic [CNT_W-1:0] lat_cnt;   // cycles since rd rose or since last valid
  logic             fire;      // word goes out at the next edge

  if (MEM_LATENCY < 1 || MEM_LATENCY > 15) begin : g_bad_latency
    $error("main_memory: MEM_LATENCY out of range");
  end

  ////////////////////////////////////////////////////////////
  // array
  ////////////////////////////////////////////////////////////

  // fixed power-up pattern, addr ^ key
  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = mem_init_word(addr_t'(i));
    end
  end

  always_ff @(posedge clk) begin
    if (mem_req.wr) begin
      mem[mem_req.addr] <= mem_req.wdata;  // taken in its own cycle
    end
  end

  ////////////////////////////////////////////////////////////
  // read latency
  ////////////////////////////////////////////////////////////

  assign fire = mem_req.rd && (lat_cnt == CNT_W'(MEM_LATENCY));

  // counts while rd is held, restarts after each word
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lat_cnt <= '0;
      mem_rsp <= '0;
    end else begin
      mem_rsp.valid <= fire;  // one cycle pulse
      if (fire) begin
        // data sampled at the address presented in the firing cycle
        mem_rsp.data <= mem[mem_req.addr];
      end
      if (!mem_req.rd || fire) begin
        lat_cnt <= '0;
      end else begin
        lat_cnt <= lat_cnt + 1'b1;
      end
    end
  end

endmodule

/* rtl/cache_subsystem.sv */
module cache_subsystem #(
  parameter int NUM_SETS    = 16,  // power of two
  parameter int MEM_LATENCY = 3    // memory read latency, 1..15
) (
  input  logic                clk,
  input  logic                arst_n,
  input  cache_pkg::cpu_req_t cpu_req,  // held by the cpu while stalled
  output cache_pkg::word_t    rdata,    // valid with hit, same cycle
  output logic                hit,
  output logic                stall
);
  import mem_pkg::*;

  ////////////////////////////////////////////////////////////
  // internal nets
  ////////////////////////////////////////////////////////////

  logic       tag_hit;           // raw compare, ignores request valid
  logic       miss_detected;
  mem_req_t   mem_req;
  mem_rsp_t   mem_rsp;
  logic       write_data_array;
  logic       write_tag_array;
  logic       cpu_wr;
  logic [2:0] fill_offset;

  // hit only means something for a live request
  assign hit           = cpu_req.valid && tag_hit;
  assign miss_detected = cpu_req.valid && !tag_hit;

  ////////////////////////////////////////////////////////////
  // lookup
  ////////////////////////////////////////////////////////////

  cache_tag_array #(
    .NUM_SETS (NUM_SETS)
  ) u_tag_array (
    .clk             (clk),
    .arst_n          (arst_n),
    .lookup_addr     (cpu_req.addr),
    .write_tag_array (write_tag_array),
    .hit             (tag_hit)
  );

  // fill words come straight off the memory response
  cache_data_array #(
    .NUM_SETS (NUM_SETS)
  ) u_data_array (
    .clk              (clk),
    .cpu_addr         (cpu_req.addr),
    .cpu_wdata        (cpu_req.wdata),
    .cpu_wr           (cpu_wr),
    .write_data_array (write_data_array),
    .fill_offset      (fill_offset),
    .fill_data        (mem_rsp.data),
    .rdata            (rdata)
  );

  ////////////////////////////////////////////////////////////
  // miss handling
  ////////////////////////////////////////////////////////////

  cache_fill_fsm u_fill_fsm (
    .clk              (clk),
    .arst_n           (arst_n),
    .cpu_req          (cpu_req),
    .miss_detected    (miss_detected),
    .mem_rsp          (mem_rsp),
    .mem_req          (mem_req),
    .stall            (stall),
    .write_data_array (write_data_array),
    .write_tag_array  (write_tag_array),
    .cpu_wr           (cpu_wr),
    .fill_offset      (fill_offset)
  );

  // block reads and write-through share one bus
  main_memory #(
    .MEM_LATENCY (MEM_LATENCY)
  ) u_main_memory (
    .clk     (clk),
    .arst_n  (arst_n),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

endmodule

/* dv/cache_props.sv */
module cache_props (
  input logic                   clk,
  input logic                   arst_n,
  input cache_pkg::fill_state_e state,
  input logic [2:0]             cnt,            // fill word counter
  input logic                   stall,
  input logic                   write_tag_array,
  input mem_pkg::mem_req_t      mem_req,
  input mem_pkg::mem_rsp_t      mem_rsp
);
  timeunit 1ns;
  timeprecision 1ps;

  import cache_pkg::*;

  ////////////////////////////////////////////////////////////
  // fill machine rules
  ////////////////////////////////////////////////////////////

  // tag and valid written with a returned word during a fill, held request hits next
  a_tag_in_fill: assert property (@(posedge clk) disable iff (!arst_n)
    write_tag_array |-> ((state == WAIT) && mem_rsp.valid) ##1 !stall)
    else $error("tag write outside a fill response or retried request missed");

  // memory only answers a block read
  a_no_rsp_idle: assert property (@(posedge clk) disable iff (!arst_n)
    (state == IDLE) |-> !mem_rsp.valid)
    else $error("memory response while the fill machine is idle");

  // a stalled cycle is always followed by a cycle in WAIT
  a_stall_state: assert property (@(posedge clk) disable iff (!arst_n)
    (state == WAIT) == $past(stall))
    else $error("stall does not follow the fill state");

  a_addr_offset: assert property (@(posedge clk) disable iff (!arst_n)
    mem_req.rd |-> (mem_req.addr[2:0] == cnt) &&
                   ($past(mem_req.rd) || (cnt == 3'd0)))  // block read starts at word 0
    else $error("block read offset differs from the word counter");

endmodule

bind cache_fill_fsm cache_props u_props (
  .clk             (clk),
  .arst_n          (arst_n),
  .state           (state),
  .cnt             (cnt),
  .stall           (stall),
  .write_tag_array (write_tag_array),
  .mem_req         (mem_req),
  .mem_rsp         (mem_rsp)
);

/* dv/tb_cache_subsystem.sv */
module tb_cache_subsystem;
  timeunit 1ns;
  timeprecision 1ps;

  import cache_pkg::*;
  import mem_pkg::*;

  localparam int    NUM_SETS    = 16;
  localparam int    MEM_LATENCY = 3;
  localparam int    IDX_W       = $clog2(NUM_SETS);
  localparam int    TAG_W       = ADDR_W - OFFSET_W - IDX_W;
  localparam int    MISS_STALL  = WORDS_PER_BLOCK * (MEM_LATENCY + 1);  // 32 at latency 3
  localparam int    STALL_LIMIT = 4 * MISS_STALL;                       // per wait
  localparam addr_t TAG_LSB     = addr_t'(1) << (OFFSET_W + IDX_W);    // lowest tag bit

  logic     clk;
  logic     arst_n;
  cpu_req_t cpu_req;
  word_t    rdata;
  logic     hit;
  logic     stall;

  ////////////////////////////////////////////////////////////
  // reference model and bookkeeping
  ////////////////////////////////////////////////////////////

  word_t            shadow_mem [1 << ADDR_W];  // expected main memory
  logic [TAG_W-1:0] shadow_tag [NUM_SETS];
  logic             shadow_valid [NUM_SETS];

  integer seed;
  int     err_cnt;
  int     test_err;      // errors in the running test
  int     tests_run;
  int     tests_failed;
  logic   first_hit;     // hit flag in the request's first cycle

  cache_subsystem #(
    .NUM_SETS    (NUM_SETS),
    .MEM_LATENCY (MEM_LATENCY)
  ) dut (
    .clk     (clk),
    .arst_n  (arst_n),
    .cpu_req (cpu_req),
    .rdata   (rdata),
    .hit     (hit),
    .stall   (stall)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  function automatic logic [IDX_W-1:0] set_of(input addr_t a);
    return a[OFFSET_W +: IDX_W];
  endfunction

  function automatic logic [TAG_W-1:0] tag_of(input addr_t a);
    return a[ADDR_W-1 -: TAG_W];
  endfunction

  function automatic logic model_hit(input addr_t a);
    return shadow_valid[set_of(a)] && (shadow_tag[set_of(a)] == tag_of(a));
  endfunction

  task automatic report_error(input string msg);
    $display("FAIL @%0t: %s", $time, msg);
    err_cnt++;
    test_err++;
  endtask

  task automatic start_test();
    test_err = 0;
    tests_run++;
  endtask

  task automatic end_test(input string name);
    if (test_err == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, test_err);
    end
  endtask

  // one request, driven on the falling edge and held until it completes
  task automatic access(input logic wr, input addr_t addr, input word_t wdata,
                        output logic got_hit);
    logic exp_hit;
    int   stalls;
    exp_hit = model_hit(addr);
    @(negedge clk);
    cpu_req.valid = 1'b1;
    cpu_req.wr    = wr;
    cpu_req.addr  = addr;
    cpu_req.wdata = wdata;
    #1;                                  // combinational answer settled
    got_hit = hit;
    stalls  = 0;
    if (hit !== exp_hit) begin
      report_error($sformatf("hit %b, expected %b, addr %h", hit, exp_hit, addr));
    end
    while (stall === 1'b1 && stalls <= STALL_LIMIT) begin
      stalls++;
      @(negedge clk);
      #1;
    end
    if (stalls > STALL_LIMIT) begin
      $display("timeout: stall never fell while filling address %h", addr);
      $display("Simulation finished: FAIL");
      $finish;
    end else begin
      if (stalls != (exp_hit ? 0 : MISS_STALL)) begin
        report_error($sformatf("stall high %0d cycles, addr %h", stalls, addr));
      end
      if (stalls != 0) begin
        @(negedge clk);                  // tag landed with the last word
        #1;
        if (hit !== 1'b1) begin
          report_error($sformatf("retried request missed, addr %h", addr));
        end
      end
      if (wr) begin
        shadow_mem[addr] = wdata;        // write-through keeps memory in step
      end else if (rdata !== shadow_mem[addr]) begin
        report_error($sformatf("rdata %h, expected %h, addr %h",
                               rdata, shadow_mem[addr], addr));
      end
      if (!exp_hit) begin
        shadow_valid[set_of(addr)] = 1'b1;
        shadow_tag[set_of(addr)]   = tag_of(addr);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rnd;
    addr_t       addr;
    cpu_req      = '0;
    arst_n       = 1'b0;
    seed         = 32'h1937;
    err_cnt      = 0;
    test_err     = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int i = 0; i < (1 << ADDR_W); i++) begin
      shadow_mem[i] = addr_t'(i) ^ MEM_INIT_KEY;  // power-up rule
    end
    for (int i = 0; i < NUM_SETS; i++) begin
      shadow_valid[i] = 1'b0;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    start_test();
    repeat (3) begin
      @(negedge clk);
      #1;
      if (stall !== 1'b0 || hit !== 1'b0) report_error("stall or hit high with no request");
    end
    access(1'b0, 16'h0040, '0, first_hit);
    if (first_hit) report_error("first read after reset hit");
    end_test("reset_idle");

    start_test();
    access(1'b0, 16'h1234, '0, first_hit);          // miss, then 32 stall cycles
    for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
      addr = 16'h1230 | addr_t'(i);                 // rest of the block
      if (addr != 16'h1234) access(1'b0, addr, '0, first_hit);
    end
    end_test("miss_then_hit");

    start_test();
    access(1'b1, 16'h1236, 16'hbeef, first_hit);
    if (!first_hit) report_error("write to a cached word missed");
    access(1'b0, 16'h1236, '0, first_hit);
    access(1'b0, 16'h1236 ^ TAG_LSB, '0, first_hit);  // same set, evicts
    access(1'b0, 16'h1236, '0, first_hit);            // refetch from memory
    if (first_hit) report_error("evicted block still hit");
    end_test("write_through");

    start_test();
    for (int i = 0; i < 8; i++) begin
      addr = (i % 2 == 0) ? 16'h0a48 : 16'h0a48 ^ (TAG_LSB << 2);
      access(1'b0, addr, '0, first_hit);
      if (first_hit) report_error($sformatf("conflicting address %h hit", addr));
    end
    end_test("conflict");

    start_test();
    for (int i = 0; i < 400; i++) begin
      rnd  = $random(seed);
      addr = {7'h00, rnd[9:1]};  // 512 words, tags 0..3 on every set
      access(rnd[0], addr, rnd[31:16], first_hit);
    end
    end_test("random_mix");

    cpu_req = '0;
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* verilog.f */
common/cache_pkg.sv
common/mem_pkg.sv
cache/cache_tag_array.sv
cache/cache_data_array.sv
cache/cache_fill_fsm.sv
rtl/main_memory.sv
rtl/cache_subsystem.sv
dv/cache_props.sv
dv/tb_cache_subsystem.sv

/* Makefile */
TOP = tb_cache_subsystem

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f verilog.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -Mdir obj_dir \
		--top-module $(TOP) -f verilog.f
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log || (echo "no pass line in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
